// File: isa_pkg.sv
`default_nettype none

package isa_pkg;

  localparam int inst_width    = 32;
  localparam int opcode_width  = 6;
  localparam int reg_idx_width = 5;

  ///////////////////////////////////////////////////////////////////////
  // instruction fields
  ///////////////////////////////////////////////////////////////////////

  localparam int op_lsb = 26;
  localparam int op_msb = op_lsb + opcode_width - 1;
  localparam int rs_msb = 25;
  localparam int rs_lsb = 21;
  localparam int rt_msb = 20;
  localparam int rt_lsb = 16;
  localparam int rd_msb = 15;
  localparam int rd_lsb = 11;

  // which fields a class reads or writes.
  localparam int mask_width = 3;
  localparam logic [mask_width-1:0] mask_none = 3'b000;
  localparam logic [mask_width-1:0] mask_rs   = 3'b001;
  localparam logic [mask_width-1:0] mask_rt   = 3'b010;
  localparam logic [mask_width-1:0] mask_rd   = 3'b100;

  ///////////////////////////////////////////////////////////////////////
  // opcodes
  ///////////////////////////////////////////////////////////////////////

  typedef enum logic [opcode_width-1:0] {
    op_nop   = 6'h00,
    op_add   = 6'h01,
    op_sub   = 6'h02,
    op_cmp   = 6'h03,
    op_test  = 6'h04,
    op_jr    = 6'h08,  // register jump sits with the reg-reg group.
    op_addi  = 6'h10,
    op_cmpi  = 6'h11,
    op_testi = 6'h12,
    op_lw    = 6'h20,
    op_sw    = 6'h21,
    op_la    = 6'h22,
    op_sa    = 6'h23,
    op_jmp   = 6'h30,
    op_je    = 6'h31
  } opcode_t;

endpackage

`default_nettype wire

// File: issue_pkg.sv
`default_nettype none

package issue_pkg;

  // execution pipe an instruction needs.
  typedef enum logic [1:0] {
    pipe_any,
    pipe_mem,
    pipe_branch
  } pipe_t;

  localparam int pc_width = 32;
  localparam int id_width = 8;

  ///////////////////////////////////////////////////////////////////////
  // pair queue
  ///////////////////////////////////////////////////////////////////////

  localparam int queue_depth     = 4;
  localparam int queue_ptr_width = $clog2(queue_depth);

endpackage

`default_nettype wire

// File: pair_queue.sv
`timescale 1ns/1ns
`default_nettype none

module pair_queue
  import isa_pkg::*, issue_pkg::*;
(
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   flush,
  input  wire                   pair_valid,
  output logic                  pair_ready,
  input  wire [inst_width-1:0]  inst0, inst1,
  input  wire [pc_width-1:0]    pc0, pc1,
  input  wire [id_width-1:0]    id0, id1,
  output logic                  head_valid,
  output logic [inst_width-1:0] head_inst0, head_inst1,
  output logic [pc_width-1:0]   head_pc0, head_pc1,
  output logic [id_width-1:0]   head_id0, head_id1,
  input  wire                   pop
);

  logic [inst_width-1:0]      inst0_mem [queue_depth];
  logic [inst_width-1:0]      inst1_mem [queue_depth];
  logic [pc_width-1:0]        pc0_mem [queue_depth];
  logic [pc_width-1:0]        pc1_mem [queue_depth];
  logic [id_width-1:0]        id0_mem [queue_depth];
  logic [id_width-1:0]        id1_mem [queue_depth];
  logic [queue_ptr_width-1:0] wr_ptr;
  logic [queue_ptr_width-1:0] rd_ptr;
  logic [queue_ptr_width:0]   count;
  logic                       push;
  logic                       drop;

  function automatic logic [queue_ptr_width-1:0] next_ptr(
    input logic [queue_ptr_width-1:0] ptr
  );
    return (ptr == queue_ptr_width'(queue_depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign pair_ready = (count != (queue_ptr_width + 1)'(queue_depth));  // back-pressure.
  assign head_valid = (count != '0);
  assign push       = pair_valid && pair_ready;
  assign drop       = pop && head_valid;

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (drop) rd_ptr <= next_ptr(rd_ptr);
      case ({push, drop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither.
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      inst0_mem[wr_ptr] <= inst0;
      inst1_mem[wr_ptr] <= inst1;
      pc0_mem[wr_ptr]   <= pc0;
      pc1_mem[wr_ptr]   <= pc1;
      id0_mem[wr_ptr]   <= id0;
      id1_mem[wr_ptr]   <= id1;
    end
  end

  assign head_inst0 = inst0_mem[rd_ptr];
  assign head_inst1 = inst1_mem[rd_ptr];
  assign head_pc0   = pc0_mem[rd_ptr];
  assign head_pc1   = pc1_mem[rd_ptr];
  assign head_id0   = id0_mem[rd_ptr];
  assign head_id1   = id1_mem[rd_ptr];

endmodule

`default_nettype wire

// File: hazard_check.sv
`timescale 1ns/1ns
`default_nettype none

module hazard_check
  import isa_pkg::*, issue_pkg::*;
(
  input  wire [inst_width-1:0]    inst_a,
  input  wire [inst_width-1:0]    inst_b,
  input  wire                     b_valid,
  input  wire                     last_load_valid,
  input  wire [reg_idx_width-1:0] last_load_rt,
  output pipe_t                   pipe_a,
  output pipe_t                   pipe_b,
  output logic                    load_use,
  output logic                    split
);

  opcode_t                  op_a;
  opcode_t                  op_b;
  logic [mask_width-1:0]    src_a;
  logic [mask_width-1:0]    src_b;
  logic [mask_width-1:0]    dst_a;
  logic [reg_idx_width-1:0] dst_reg_a;
  logic                     depend;
  logic                     conflict;

  ///////////////////////////////////////////////////////////////////////
  // decode
  ///////////////////////////////////////////////////////////////////////

  function automatic logic [mask_width-1:0] src_of(input opcode_t op);
    case (op)
      op_add, op_sub, op_cmp, op_test, op_sw:    return mask_rs | mask_rt;
      op_addi, op_cmpi, op_testi, op_jr, op_lw:  return mask_rs;
      op_sa:                                     return mask_rt;
      default:                                   return mask_none;
    endcase
  endfunction

  function automatic logic [mask_width-1:0] dst_of(input opcode_t op);
    case (op)
      op_add, op_sub:        return mask_rd;
      op_addi, op_lw, op_la: return mask_rt;
      default:               return mask_none;  // compares only set flags.
    endcase
  endfunction

  function automatic pipe_t pipe_class(input opcode_t op);
    case (op)
      op_lw, op_sw, op_la, op_sa:                               return pipe_mem;
      op_cmp, op_test, op_cmpi, op_testi, op_jr, op_jmp, op_je: return pipe_branch;
      default:                                                  return pipe_any;
    endcase
  endfunction

  function automatic logic reads_reg(input logic [inst_width-1:0]    inst,
                                     input logic [mask_width-1:0]    src,
                                     input logic [reg_idx_width-1:0] r);
    return ((src & mask_rs) != mask_none && inst[rs_msb:rs_lsb] == r) ||
           ((src & mask_rt) != mask_none && inst[rt_msb:rt_lsb] == r);
  endfunction

  assign op_a   = opcode_t'(inst_a[op_msb:op_lsb]);
  assign op_b   = opcode_t'(inst_b[op_msb:op_lsb]);
  assign src_a  = src_of(op_a);
  assign src_b  = src_of(op_b);
  assign dst_a  = dst_of(op_a);
  assign pipe_a = pipe_class(op_a);
  assign pipe_b = pipe_class(op_b);

  ///////////////////////////////////////////////////////////////////////
  // hazards
  ///////////////////////////////////////////////////////////////////////

  assign dst_reg_a = ((dst_a & mask_rd) != mask_none) ? inst_a[rd_msb:rd_lsb]
                                                       : inst_a[rt_msb:rt_lsb];
  assign depend    = (dst_a != mask_none) && reads_reg(inst_b, src_b, dst_reg_a);
  assign conflict  = (pipe_a == pipe_b) && (pipe_a != pipe_any);  // one mem, one br pipe.
  assign split     = b_valid && (depend || conflict);

  assign load_use = last_load_valid &&
                    (reads_reg(inst_a, src_a, last_load_rt) ||
                     (b_valid && reads_reg(inst_b, src_b, last_load_rt)));

endmodule

`default_nettype wire

// File: issue_stage.sv
`timescale 1ns/1ns
`default_nettype none

module issue_stage
  import isa_pkg::*, issue_pkg::*;
(
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   flush,
  input  wire                   head_valid,
  input  wire [inst_width-1:0]  head_inst0, head_inst1,
  input  wire [pc_width-1:0]    head_pc0, head_pc1,
  input  wire [id_width-1:0]    head_id0, head_id1,
  output logic                  pop,
  output logic                  iss_valid0, iss_valid1,
  output logic [inst_width-1:0] iss_inst0, iss_inst1,
  output logic [pc_width-1:0]   iss_pc0, iss_pc1,
  output logic [id_width-1:0]   iss_id0, iss_id1,
  output pipe_t                 iss_pipe0, iss_pipe1
);

  logic                     held_valid;
  logic [inst_width-1:0]    held_inst;
  logic [pc_width-1:0]      held_pc;
  logic [id_width-1:0]      held_id;
  logic                     last_load_valid;
  logic [reg_idx_width-1:0] last_load_rt;
  logic                     a_valid;
  logic                     b_valid;
  logic                     load_use;
  logic                     split;
  logic                     go;

  function automatic logic is_load(input logic [inst_width-1:0] inst);
    return opcode_t'(inst[op_msb:op_lsb]) inside {op_lw, op_la};
  endfunction

  ///////////////////////////////////////////////////////////////////////
  // candidate select and issue decision
  ///////////////////////////////////////////////////////////////////////

  // a held instruction is older than the head pair.
  assign a_valid   = held_valid || head_valid;
  assign b_valid   = !held_valid && head_valid;
  assign iss_inst0 = held_valid ? held_inst : head_inst0;
  assign iss_pc0   = held_valid ? held_pc : head_pc0;
  assign iss_id0   = held_valid ? held_id : head_id0;
  assign iss_inst1 = head_inst1;
  assign iss_pc1   = head_pc1;
  assign iss_id1   = head_id1;

  hazard_check hazard_check_i (
    .inst_a          (iss_inst0),
    .inst_b          (head_inst1),
    .b_valid         (b_valid),
    .last_load_valid (last_load_valid),
    .last_load_rt    (last_load_rt),
    .pipe_a          (iss_pipe0),
    .pipe_b          (iss_pipe1),
    .load_use        (load_use),
    .split           (split)
  );

  assign go         = a_valid && !load_use;  // load-use gives a bubble.
  assign iss_valid0 = go;
  assign iss_valid1 = go && b_valid && !split;
  assign pop        = go && b_valid;

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      held_valid      <= 1'b0;
      last_load_valid <= 1'b0;
    end else begin
      if (go) held_valid <= pop && split;
      last_load_valid <= (iss_valid0 && is_load(iss_inst0)) ||
                         (iss_valid1 && is_load(iss_inst1));
    end
  end

  always_ff @(posedge clk) begin
    if (pop && split) begin
      held_inst <= head_inst1;
      held_pc   <= head_pc1;
      held_id   <= head_id1;
    end
    if (iss_valid1 && is_load(iss_inst1)) begin
      last_load_rt <= iss_inst1[rt_msb:rt_lsb];
    end else begin
      last_load_rt <= iss_inst0[rt_msb:rt_lsb];  // only read when valid.
    end
  end

endmodule

`default_nettype wire

// File: pipe_dispatch.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_dispatch
  import isa_pkg::*, issue_pkg::*;
(
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   flush,
  input  wire                   iss_valid0, iss_valid1,
  input  wire [inst_width-1:0]  iss_inst0, iss_inst1,
  input  wire [pc_width-1:0]    iss_pc0, iss_pc1,
  input  wire [id_width-1:0]    iss_id0, iss_id1,
  input  wire pipe_t            iss_pipe0, iss_pipe1,
  output logic                  alu0_valid, alu1_valid, mem_valid, br_valid,
  output logic [inst_width-1:0] alu0_inst, alu1_inst, mem_inst, br_inst,
  output logic [pc_width-1:0]   alu0_pc, alu1_pc, mem_pc, br_pc,
  output logic [id_width-1:0]   alu0_id, alu1_id, mem_id, br_id
);

  logic live0, live1;
  logic alu_hit0, alu_hit1;
  logic mem_hit0, mem_hit1;
  logic br_hit0, br_hit1;

  // nops take no port.
  assign live0    = iss_valid0 && (opcode_t'(iss_inst0[op_msb:op_lsb]) != op_nop);
  assign live1    = iss_valid1 && (opcode_t'(iss_inst1[op_msb:op_lsb]) != op_nop);
  assign alu_hit0 = live0 && (iss_pipe0 == pipe_any);
  assign alu_hit1 = live1 && (iss_pipe1 == pipe_any);
  assign mem_hit0 = live0 && (iss_pipe0 == pipe_mem);
  assign mem_hit1 = live1 && (iss_pipe1 == pipe_mem);
  assign br_hit0  = live0 && (iss_pipe0 == pipe_branch);
  assign br_hit1  = live1 && (iss_pipe1 == pipe_branch);

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      alu0_valid <= 1'b0;
      alu1_valid <= 1'b0;
      mem_valid  <= 1'b0;
      br_valid   <= 1'b0;
    end else begin
      alu0_valid <= alu_hit0 || alu_hit1;
      alu1_valid <= alu_hit0 && alu_hit1;  // second alu op only.
      mem_valid  <= mem_hit0 || mem_hit1;
      br_valid   <= br_hit0 || br_hit1;
    end
  end

  always_ff @(posedge clk) begin
    alu0_inst <= alu_hit0 ? iss_inst0 : iss_inst1;
    alu0_pc   <= alu_hit0 ? iss_pc0 : iss_pc1;
    alu0_id   <= alu_hit0 ? iss_id0 : iss_id1;
    alu1_inst <= iss_inst1;
    alu1_pc   <= iss_pc1;
    alu1_id   <= iss_id1;
    mem_inst  <= mem_hit0 ? iss_inst0 : iss_inst1;
    mem_pc    <= mem_hit0 ? iss_pc0 : iss_pc1;
    mem_id    <= mem_hit0 ? iss_id0 : iss_id1;
    br_inst   <= br_hit0 ? iss_inst0 : iss_inst1;
    br_pc     <= br_hit0 ? iss_pc0 : iss_pc1;
    br_id     <= br_hit0 ? iss_id0 : iss_id1;
  end

endmodule

`default_nettype wire

// File: dual_issue_top.sv
`timescale 1ns/1ns
`default_nettype none

module dual_issue_top
  import isa_pkg::*, issue_pkg::*;
(
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   flush,
  input  wire                   pair_valid,
  output logic                  pair_ready,
  input  wire [inst_width-1:0]  inst0, inst1,
  input  wire [pc_width-1:0]    pc0, pc1,
  input  wire [id_width-1:0]    id0, id1,
  output logic                  alu0_valid, alu1_valid, mem_valid, br_valid,
  output logic [inst_width-1:0] alu0_inst, alu1_inst, mem_inst, br_inst,
  output logic [pc_width-1:0]   alu0_pc, alu1_pc, mem_pc, br_pc,
  output logic [id_width-1:0]   alu0_id, alu1_id, mem_id, br_id
);

  // queue head.
  logic                  head_valid;
  logic [inst_width-1:0] head_inst0, head_inst1;
  logic [pc_width-1:0]   head_pc0, head_pc1;
  logic [id_width-1:0]   head_id0, head_id1;
  logic                  pop;

  // issued slots, slot 0 older.
  logic                  iss_valid0, iss_valid1;
  logic [inst_width-1:0] iss_inst0, iss_inst1;
  logic [pc_width-1:0]   iss_pc0, iss_pc1;
  logic [id_width-1:0]   iss_id0, iss_id1;
  pipe_t                 iss_pipe0, iss_pipe1;

  pair_queue pair_queue_i (.*);

  issue_stage issue_stage_i (.*);

  pipe_dispatch pipe_dispatch_i (.*);

endmodule

`default_nettype wire

// File: dual_issue_assert.sv
`timescale 1ns/1ns
`default_nettype none

module dual_issue_assert
  import issue_pkg::*;
(
  input wire                clk,
  input wire                reset,
  input wire                flush,
  input wire                pair_valid,
  input wire                pair_ready,
  input wire                pop,
  input wire                head_valid,
  input wire                alu0_valid, alu1_valid, mem_valid, br_valid,
  input wire [id_width-1:0] mem_id, br_id
);

  localparam int fill_width = queue_ptr_width + 1;

  logic [fill_width-1:0] fill;  // queue occupancy seen from outside.
  logic                  quiet;

  assign quiet = !(alu0_valid || alu1_valid || mem_valid || br_valid);

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      fill <= '0;
    end else begin
      fill <= fill + fill_width'(pair_valid && pair_ready) - fill_width'(pop && head_valid);
    end
  end

  ready_when_room: assert property (@(posedge clk) disable iff (reset)
    (fill != fill_width'(queue_depth)) |-> pair_ready)
    else $error("pair_ready low while the queue has room");

  // second cycle shows the emptied queue and held slot.
  quiet_after_flush: assert property (@(posedge clk) disable iff (reset)
    flush |=> quiet ##1 quiet)
    else $error("a port was valid within two cycles after flush");

  distinct_mem_br: assert property (@(posedge clk) disable iff (reset)
    (mem_valid && br_valid) |-> (mem_id != br_id))
    else $error("mem and br carried the same id");

endmodule

`default_nettype wire

// File: tb_dual_issue.sv
`timescale 1ns/1ns
`default_nettype none

module tb_dual_issue
  import isa_pkg::*, issue_pkg::*;
;

  localparam int max_rec = 64;

  logic                  clk = 1'b0;
  logic                  reset, flush, pair_valid, pair_ready;
  logic [inst_width-1:0] inst0, inst1;
  logic [pc_width-1:0]   pc0, pc1;
  logic [id_width-1:0]   id0, id1;
  logic                  alu0_valid, alu1_valid, mem_valid, br_valid;
  logic [inst_width-1:0] alu0_inst, alu1_inst, mem_inst, br_inst;
  logic [pc_width-1:0]   alu0_pc, alu1_pc, mem_pc, br_pc;
  logic [id_width-1:0]   alu0_id, alu1_id, mem_id, br_id;

  byte                   rec_kind [max_rec];
  logic [inst_width-1:0] rec_inst0 [max_rec], rec_inst1 [max_rec];
  logic [pc_width-1:0]   rec_pc0 [max_rec], rec_pc1 [max_rec];
  logic [id_width-1:0]   rec_id0 [max_rec], rec_id1 [max_rec];
  int                    rec_wait [max_rec];  // arrivals due before a drain.
  logic [id_width-1:0]   exp_alu0 [$], exp_alu1 [$], exp_mem [$], exp_br [$];
  logic [inst_width-1:0] inst_of_id [2**id_width];  // golden inst and pc by id.
  logic [pc_width-1:0]   pc_of_id [2**id_width];
  int                    n_rec = 0, n_pairs = 0, n_expected = 0, n_seen = 0;
  int                    cycles = 0, limit = 0;
  logic [31:0]           lfsr;

  dual_issue_top dual_issue_top_i (.*);

  bind dual_issue_top dual_issue_assert dual_issue_assert_i (.*);

  always #4 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1, "run stopped");
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1.
  endfunction

  function automatic pipe_t class_of(input logic [inst_width-1:0] inst);
    case (opcode_t'(inst[op_msb:op_lsb]))
      op_lw, op_sw, op_la, op_sa:                               return pipe_mem;
      op_cmp, op_test, op_cmpi, op_testi, op_jr, op_jmp, op_je: return pipe_branch;
      default:                                                  return pipe_any;
    endcase
  endfunction

  task automatic check_id(input string test, input logic [id_width-1:0] expected,
                          input logic [id_width-1:0] actual);
    if (actual !== expected)
      stop_with_failure($sformatf("Mismatch %s id: expected %02h, actual %02h",
                                  test, expected, actual));
  endtask

  task automatic check_inst(input string test, input logic [inst_width-1:0] expected,
                            input logic [inst_width-1:0] actual);
    if (actual !== expected)
      stop_with_failure($sformatf("Mismatch %s inst: expected %08h, actual %08h",
                                  test, expected, actual));
  endtask

  task automatic check_pc(input string test, input logic [pc_width-1:0] expected,
                          input logic [pc_width-1:0] actual);
    if (actual !== expected)
      stop_with_failure($sformatf("Mismatch %s pc: expected %08h, actual %08h",
                                  test, expected, actual));
  endtask

  task automatic check_pipe(input string test, input pipe_t expected, input pipe_t actual);
    if (actual !== expected)
      stop_with_failure($sformatf("Mismatch %s class: expected %s, actual %s",
                                  test, expected.name(), actual.name()));
  endtask

  task automatic observe(ref logic [id_width-1:0] q [$], input string port,
                         input pipe_t port_class, input logic [inst_width-1:0] inst,
                         input logic [pc_width-1:0] pc, input logic [id_width-1:0] id);
    logic [id_width-1:0] expected;
    if (opcode_t'(inst[op_msb:op_lsb]) == op_nop)
      stop_with_failure({"a nop was dispatched on port ", port});
    if (q.size() == 0)
      stop_with_failure($sformatf("unexpected id %02h on port %s", id, port));
    expected = q.pop_front();
    check_pipe({port, " port"}, port_class, class_of(inst));
    check_id({port, " port"}, expected, id);
    check_inst({port, " port"}, inst_of_id[expected], inst);
    check_pc({port, " port"}, pc_of_id[expected], pc);
    n_seen++;
  endtask

  task automatic read_golden();
    int                  fd;
    int                  n;
    string               line;
    string               kind;
    string               port;
    logic [id_width-1:0] id;
    fd = $fopen("issue_golden.txt", "r");
    if (fd == 0) stop_with_failure("cannot open issue_golden.txt");
    while ($fgets(line, fd) != 0) begin
      n = $sscanf(line, "%s", kind);
      if (n != 1 || kind == "#") continue;
      if (kind == "E") begin
        n = $sscanf(line, "%s %s %h", kind, port, id);
        case (port)
          "alu0":  exp_alu0.push_back(id);
          "alu1":  exp_alu1.push_back(id);
          "mem":   exp_mem.push_back(id);
          "br":    exp_br.push_back(id);
          default: stop_with_failure({"unknown port name in golden file: ", port});
        endcase
        n_expected++;
        continue;
      end
      if (kind == "P") begin
        n = $sscanf(line, "%s %h %h %h %h %h %h", kind, rec_inst0[n_rec], rec_inst1[n_rec],
                    rec_pc0[n_rec], rec_pc1[n_rec], rec_id0[n_rec], rec_id1[n_rec]);
        if (n != 7) stop_with_failure({"bad pair record: ", line});
        inst_of_id[rec_id0[n_rec]] = rec_inst0[n_rec];
        inst_of_id[rec_id1[n_rec]] = rec_inst1[n_rec];
        pc_of_id[rec_id0[n_rec]]   = rec_pc0[n_rec];
        pc_of_id[rec_id1[n_rec]]   = rec_pc1[n_rec];
        n_pairs++;
      end else if (kind != "D" && kind != "F") begin
        stop_with_failure({"unknown record in golden file: ", line});
      end
      rec_kind[n_rec] = kind[0];
      rec_wait[n_rec] = n_expected;
      n_rec++;
    end
    $fclose(fd);
  endtask

  task automatic send_pair(input int r);
    lfsr = lfsr_step(lfsr);
    if (lfsr[0]) @(negedge clk);  // idle cycle.
    pair_valid = 1'b1;
    inst0      = rec_inst0[r];
    inst1      = rec_inst1[r];
    pc0        = rec_pc0[r];
    pc1        = rec_pc1[r];
    id0        = rec_id0[r];
    id1        = rec_id1[r];
    while (!pair_ready) @(negedge clk);
    @(negedge clk);
    pair_valid = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // monitor, timeout, main sequence
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!reset) begin
      if (alu0_valid) observe(exp_alu0, "alu0", pipe_any, alu0_inst, alu0_pc, alu0_id);
      if (alu1_valid) observe(exp_alu1, "alu1", pipe_any, alu1_inst, alu1_pc, alu1_id);
      if (mem_valid) observe(exp_mem, "mem", pipe_mem, mem_inst, mem_pc, mem_id);
      if (br_valid) observe(exp_br, "br", pipe_branch, br_inst, br_pc, br_id);
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > limit) stop_with_failure($sformatf("timeout after %0d cycles", cycles));
  end

  initial begin
    reset      = 1'b1;
    flush      = 1'b0;
    pair_valid = 1'b0;
    inst0      = '0;
    inst1      = '0;
    pc0        = '0;
    pc1        = '0;
    id0        = '0;
    id1        = '0;
    lfsr       = 32'ha9c3093c;
    read_golden();
    limit = 20 * n_pairs + 50;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int r = 0; r < n_rec; r++) begin
      case (rec_kind[r])
        "P": send_pair(r);
        "D": while (n_seen < rec_wait[r]) @(negedge clk);
        default: begin
          flush = 1'b1;  // one cycle, right after the last accepted pair.
          @(negedge clk);
          flush = 1'b0;
        end
      endcase
    end
    while (n_seen < n_expected && cycles < limit) @(negedge clk);
    if (n_seen != n_expected) begin
      stop_with_failure($sformatf("%0d expected ids never arrived", n_expected - n_seen));
    end else begin
      repeat (8) @(negedge clk);  // a stray late id still shows here.
      $display("** PASS **");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: filelist.f
isa_pkg.sv
issue_pkg.sv
pair_queue.sv
hazard_check.sv
issue_stage.sv
pipe_dispatch.sv
dual_issue_top.sv
dual_issue_assert.sv
tb_dual_issue.sv

// File: Makefile
TOP = tb_dual_issue

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass line in sim.log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx '\*\* PASS \*\*' sim.log

clean:
	rm -rf obj_dir sim.log

// File: issue_golden.txt
# P inst0 inst1 pc0 pc1 id0 id1 | E port id, per port in program order (hex)
# D waits for every E listed above it | F pulses flush right after the last pair
P 04221800 84850000 00001000 00001004 01 02
P 04222000 08222800 00001008 0000100c 03 04
P 04223000 08c23800 00001010 00001014 05 06
P 40280000 85020000 00001018 0000101c 07 08
P 84220000 84650000 00001020 00001024 09 0a
P 0c220000 c0000000 00001028 0000102c 0b 0c
P 80230000 04624800 00001030 00001034 0d 0e
P 80450000 00000000 00001038 0000103c 0f 10
P 08a11800 c4000000 00001040 00001044 11 12
E alu0 01
E alu0 03
E alu0 05
E alu0 06
E alu0 07
E alu0 0e
E alu0 11
E alu1 04
E mem 02
E mem 08
E mem 09
E mem 0a
E mem 0d
E mem 0f
E br 0b
E br 0c
E br 12
D
P 04221800 0c220000 00002000 00002004 13 14
F
P 04222000 84850000 00003000 00003004 15 16
E alu0 15
E mem 16
